/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*;
(
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                valid,
    input  logic                                op,        // 1 write, 0 read
    input  index_t                              index,
    input  tag_t                                tag,
    input  logic [OFFSET_W-1:0]                 offset,
    input  strb_t                               wstrb,
    input  word_t                               wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output word_t                               rdata,
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0]   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  word_t                               ret_data,
    output logic                                wr_req,
    output logic [2:0]                          wr_type,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0]   wr_addr,
    output strb_t                               wr_wstrb,
    output line_t                               wr_data,
    input  logic                                wr_rdy,
    way_if.ctrl                                 w0,
    way_if.ctrl                                 w1
);

    cache_state_t state;
    cache_state_t state_nxt;

    logic                req_op;
    index_t              req_index;
    tag_t                req_tag;
    logic [OFFSET_W-1:0] req_offset;
    strb_t               req_wstrb;
    word_t               req_wdata;
    bank_sel_t           req_bank;

    logic      rep_first;   // first REPLACE cycle, victim still on the way outputs
    logic      rep_way;
    logic      rep_dirty;
    tag_t      rep_tag;
    line_t     rep_line;
    bank_sel_t beat_cnt;

    logic   hit0;
    logic   hit1;
    logic   cache_hit;
    logic   victim_way;
    tag_t   victim_tag;
    line_t  victim_line;
    logic   victim_dirty;
    logic   wb_dirty;
    logic   accept;
    logic   reread;
    logic   fill_beat;
    word_t  load_word;
    word_t  strb_mask;
    word_t  fill_word;
    word_t  way_wdata;
    logic   dirty_in;
    index_t way_index;
    tag_v_t fill_tag_v;
    logic [1:0][LINE_WORDS-1:0][STRB_W-1:0] bank_we;
    logic [1:0] tag_we;
    logic [1:0] dirty_we;

    assign accept    = state == IDLE && valid;
    assign reread    = state == MISS && wr_rdy;   // MISS -> REPLACE
    assign fill_beat = state == REFILL && ret_valid;
    assign req_bank  = req_offset[OFFSET_W-1:2];

    assign hit0      = w0.tag_v.valid && w0.tag_v.tag == req_tag;
    assign hit1      = w1.tag_v.valid && w1.tag_v.tag == req_tag;
    assign cache_hit = hit0 || hit1;
    assign load_word = hit1 ? w1.line[req_bank*WORD_W +: WORD_W]
                            : w0.line[req_bank*WORD_W +: WORD_W];

    // first invalid way, else way 0
    assign victim_way   = w0.tag_v.valid && !w1.tag_v.valid;
    assign victim_tag   = victim_way ? w1.tag_v.tag : w0.tag_v.tag;
    assign victim_line  = victim_way ? w1.line : w0.line;
    assign victim_dirty = victim_way ? w1.dirty : w0.dirty;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:    if (valid) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = cache_hit ? IDLE : MISS;
            MISS:    if (wr_rdy) state_nxt = REPLACE;
            REPLACE: if (!rep_first && rd_rdy) state_nxt = REFILL;
            REFILL:  if (ret_valid && ret_last) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            rep_first <= 1'b0;
            rep_way   <= 1'b0;
            rep_dirty <= 1'b0;
            beat_cnt  <= '0;
        end
        else
        begin
            state     <= state_nxt;
            rep_first <= reread;
            if (rep_first)
            begin
                rep_way   <= victim_way;
                rep_dirty <= victim_dirty;
            end
            if (state == REPLACE && state_nxt == REFILL)
                beat_cnt <= '0;
            else if (fill_beat)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
        if (rep_first)
        begin
            rep_tag  <= victim_tag;
            rep_line <= victim_line;
        end
    end

    always_comb
    begin
        for (int i = 0; i < STRB_W; i++)
            strb_mask[i*(WORD_W/STRB_W) +: WORD_W/STRB_W] = {(WORD_W/STRB_W){req_wstrb[i]}};
    end

    // store bytes go over the refilled word of a write miss
    assign fill_word = (req_op && beat_cnt == req_bank)
                     ? (req_wdata & strb_mask) | (ret_data & ~strb_mask)
                     : ret_data;

    always_comb
    begin
        bank_we  = '0;
        tag_we   = '0;
        dirty_we = '0;
        if (state == LOOKUP && req_op && cache_hit)
        begin
            bank_we[hit1][req_bank] = req_wstrb;   // hit write, bank port is free here
            dirty_we[hit1]          = 1'b1;
        end
        if (fill_beat)
        begin
            bank_we[rep_way][beat_cnt] = '1;
            tag_we[rep_way]            = ret_last;
            dirty_we[rep_way]          = ret_last;
        end
    end

    assign way_index  = (state == IDLE) ? index : req_index;
    assign way_wdata  = (state == REFILL) ? fill_word : req_wdata;
    assign dirty_in   = (state == REFILL) ? req_op : 1'b1;
    assign fill_tag_v = '{tag: req_tag, valid: 1'b1};

    assign w0.en       = accept || reread;
    assign w0.line_rd  = reread;
    assign w0.rd_bank  = offset[OFFSET_W-1:2];
    assign w0.index    = way_index;
    assign w0.bank_we  = bank_we[0];
    assign w0.wdata    = way_wdata;
    assign w0.tag_v_we = tag_we[0];
    assign w0.tag_v_in = fill_tag_v;
    assign w0.dirty_we = dirty_we[0];
    assign w0.dirty_in = dirty_in;

    assign w1.en       = accept || reread;
    assign w1.line_rd  = reread;
    assign w1.rd_bank  = offset[OFFSET_W-1:2];
    assign w1.index    = way_index;
    assign w1.bank_we  = bank_we[1];
    assign w1.wdata    = way_wdata;
    assign w1.tag_v_we = tag_we[1];
    assign w1.tag_v_in = fill_tag_v;
    assign w1.dirty_we = dirty_we[1];
    assign w1.dirty_in = dirty_in;

    assign addr_ok = state == IDLE;
    assign data_ok = (state == LOOKUP && (cache_hit || req_op))
                  || (fill_beat && !req_op && beat_cnt == req_bank);
    assign rdata   = (state == REFILL) ? ret_data : load_word;

    assign rd_req  = state == REPLACE && !rep_first;
    assign rd_type = BURST_TYPE;
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    // victim comes live from the ways in the first cycle, then from the buffer
    assign wb_dirty = rep_first ? victim_dirty : rep_dirty;
    assign wr_req   = rep_first && victim_dirty;
    assign wr_type  = BURST_TYPE;
    assign wr_addr  = {(rep_first ? victim_tag : rep_tag), req_index, {OFFSET_W{1'b0}}};
    assign wr_wstrb = {STRB_W{wb_dirty}};
    assign wr_data  = rep_first ? victim_line : rep_line;

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 8;
    localparam int OFFSET_W   = 4;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int STRB_W     = 4;
    localparam int NUM_SETS   = 256;

    localparam logic [2:0] BURST_TYPE = 3'b100; // full line, four beats

    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [STRB_W-1:0]            strb_t;
    typedef logic [1:0]                   bank_sel_t; // word within a line
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;     // word 0 in the low bits

    // tag RAM entry
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tag_v_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } cache_state_t;

endpackage

/* rtl/cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*;
(
    input  logic                                clk,
    input  logic                                resetn,
    // cpu side
    input  logic                                valid,
    input  logic                                op,
    input  index_t                              index,
    input  tag_t                                tag,
    input  logic [OFFSET_W-1:0]                 offset,
    input  strb_t                               wstrb,
    input  word_t                               wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output word_t                               rdata,
    // memory side
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0]   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  word_t                               ret_data,
    output logic                                wr_req,
    output logic [2:0]                          wr_type,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0]   wr_addr,
    output strb_t                               wr_wstrb,
    output line_t                               wr_data,
    input  logic                                wr_rdy
);

    way_if w0_if ();
    way_if w1_if ();

    cache_ctrl ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .w0        (w0_if),
        .w1        (w1_if)
    );

    cache_way way0 (
        .clk    (clk),
        .resetn (resetn),
        .port   (w0_if)
    );

    cache_way way1 (
        .clk    (clk),
        .resetn (resetn),
        .port   (w1_if)
    );

endmodule

/* rtl/cache_way.sv */
`timescale 1ns/1ps

module cache_way import cache_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    way_if.way   port
);

    tag_v_t              tag_dout;
    logic                tag_en;
    logic [NUM_SETS-1:0] valid_tbl;
    logic                valid_q;    // valid bit of the last tag read
    logic [NUM_SETS-1:0] dirty_tbl;

    for (genvar b = 0; b < LINE_WORDS; b++)
    begin : g_bank
        logic  bank_en;
        word_t bank_dout;

        // a cpu lookup only needs the addressed word
        assign bank_en = (port.en && (port.line_rd || port.rd_bank == bank_sel_t'(b)))
                      || (|port.bank_we[b]);

        sram_sp #(
            .payload_t (word_t),
            .LANES     (STRB_W)
        ) u_bank (
            .clk  (clk),
            .en   (bank_en),
            .we   (port.bank_we[b]),
            .addr (port.index),
            .din  (port.wdata),
            .dout (bank_dout)
        );

        assign port.line[b*WORD_W +: WORD_W] = bank_dout;
    end

    assign tag_en = port.en || port.tag_v_we;

    sram_sp #(
        .payload_t (tag_v_t),
        .LANES     (1)
    ) u_tag (
        .clk  (clk),
        .en   (tag_en),
        .we   (port.tag_v_we),
        .addr (port.index),
        .din  (port.tag_v_in),
        .dout (tag_dout)
    );

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            valid_tbl <= '0;
            valid_q   <= 1'b0;
        end
        else
        begin
            if (port.tag_v_we)
                valid_tbl[port.index] <= port.tag_v_in.valid;
            if (tag_en)
                valid_q <= valid_tbl[port.index]; // same timing as the tag RAM
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            dirty_tbl <= '0;
        else if (port.dirty_we)
            dirty_tbl[port.index] <= port.dirty_in;
    end

    assign port.tag_v = '{tag: tag_dout.tag, valid: valid_q};
    assign port.dirty = dirty_tbl[port.index];

endmodule

/* rtl/sram_sp.sv */
`timescale 1ns/1ps

module sram_sp import cache_pkg::*;
#(
    parameter type payload_t = word_t,
    parameter int  LANES     = 1
)
(
    input  logic             clk,
    input  logic             en,
    input  logic [LANES-1:0] we,
    input  index_t           addr,
    input  payload_t         din,
    output payload_t         dout
);

    logic [$bits(payload_t)-1:0] mem [NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (we[l])
                begin
                    mem[addr][l*($bits(payload_t)/LANES) +: $bits(payload_t)/LANES]
                        <= din[l*($bits(payload_t)/LANES) +: $bits(payload_t)/LANES];
                end
            end
            dout <= payload_t'(mem[addr]); // old contents on a write cycle
        end
    end

endmodule

/* rtl/way_if.sv */
`timescale 1ns/1ps

interface way_if import cache_pkg::*; ();

    // controller to way
    logic                                en;       // read access, tag and data
    index_t                              index;
    bank_sel_t                           rd_bank;  // only bank read on a cpu lookup
    logic                                line_rd;  // read all four banks
    logic [LINE_WORDS-1:0][STRB_W-1:0]   bank_we;  // byte lanes per bank
    word_t                               wdata;
    logic                                tag_v_we;
    tag_v_t                              tag_v_in;
    logic                                dirty_we;
    logic                                dirty_in;

    // way to controller
    line_t                               line;     // registered, one cycle after en
    tag_v_t                              tag_v;    // registered, one cycle after en
    logic                                dirty;    // combinational from index

    modport ctrl (
        output en, index, rd_bank, line_rd, bank_we, wdata,
        output tag_v_we, tag_v_in, dirty_we, dirty_in,
        input  line, tag_v, dirty
    );

    modport way (
        input  en, index, rd_bank, line_rd, bank_we, wdata,
        input  tag_v_we, tag_v_in, dirty_we, dirty_in,
        output line, tag_v, dirty
    );

endinterface

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_cache -o tb_cache

./obj_dir/tb_cache > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished without failures"
exit 0

/* src.f */
rtl/cache_pkg.sv
rtl/way_if.sv
rtl/sram_sp.sv
rtl/cache_way.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/mem_model.sv
testbench/tb_cache.sv

/* testbench/mem_model.sv */
`timescale 1ns/1ps

module mem_model import cache_pkg::*;
#(
    parameter word_t       FILL_XOR = 32'h5a3c_96e1,
    parameter logic [31:0] SEED     = 32'hab80_12d7
)
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output word_t       ret_data,
    input  logic        wr_req,
    input  logic [31:0] wr_addr,
    input  line_t       wr_data,
    output logic        wr_rdy
);

    word_t       mem [logic [31:0]];  // written-back words, keyed by byte address
    logic [31:0] lfsr;
    logic [31:0] rd_base;
    logic        busy;
    int          beat;
    int          gap;                 // idle cycles before the next beat

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t read_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return a ^ FILL_XOR;
    endfunction

    assign rd_rdy = 1'b1;
    assign wr_rdy = 1'b1;

    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            busy      <= 1'b0;
            beat      <= 0;
            gap       <= 0;
            lfsr      = SEED;
        end
        else
        begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req)
            begin
                for (int i = 0; i < LINE_WORDS; i++)
                    mem[wr_addr + 32'(4 * i)] = wr_data[i*WORD_W +: WORD_W];
            end
            if (rd_req && !busy)
            begin
                busy    <= 1'b1;
                rd_base <= rd_addr;
                beat    <= 0;
            end
            else if (busy && gap > 0)
                gap <= gap - 1;
            else if (busy)
            begin
                ret_valid <= 1'b1;
                ret_last  <= beat == LINE_WORDS - 1;
                ret_data  <= read_word(rd_base + 32'(4 * beat));
                beat      <= beat + 1;
                busy      <= beat != LINE_WORDS - 1;
                lfsr      = lfsr_next(lfsr);   // two bits per gap
                lfsr      = lfsr_next(lfsr);
                gap       <= int'(lfsr[1:0]);
            end
        end
    end

endmodule

/* testbench/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_RANDOM     = 200;
    localparam int          N_REQ        = 9 + N_RANDOM;
    localparam int          MISS_CYCLES  = 40;   // worst case per request
    localparam word_t       FILL_XOR     = 32'h5a3c_96e1;
    localparam logic [31:0] SEED         = 32'hab80_12d7;
    localparam tag_t        TAG_BASE     = 20'h00a00;
    localparam index_t      IDX_BASE     = 8'h40;

    logic        clk = 1'b0;
    logic        resetn;
    logic        valid;
    logic        op;
    index_t      index;
    tag_t        tag;
    logic [3:0]  offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [2:0]  wr_type;
    logic [31:0] wr_addr;
    strb_t       wr_wstrb;
    line_t       wr_data;
    logic        wr_rdy;

    logic [7:0]  ref_mem [logic [31:0]];  // bytes stored by the cpu
    logic [31:0] rng = SEED;
    logic        cur_op;
    bank_sel_t   cur_word;
    logic        expect_hit;
    logic        expect_clean;
    logic        check_wb_addr;
    logic [31:0] exp_wb_addr;
    logic [31:0] req_line;
    word_t       exp_rdata;
    line_t       exp_wb_line;
    logic        reset_q;
    logic        after_reset;
    logic        lookup_q;                // cycle after acceptance
    logic        wr_req_q;
    logic [2:0]  beat_no;
    int          wb_cnt;
    int          rd_cnt;
    int          err_cnt;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    cache_top dut (.*);

    mem_model #(
        .FILL_XOR (FILL_XOR),
        .SEED     (SEED)
    ) mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        word_t fill;
        fill = {a[31:2], 2'b00} ^ FILL_XOR;
        if (ref_mem.exists(a))
            return ref_mem[a];
        return fill[a[1:0]*8 +: 8];
    endfunction

    function automatic word_t ref_word(input logic [31:0] a);
        word_t w;
        for (int i = 0; i < 4; i++)
            w[i*8 +: 8] = ref_byte(a + 32'(i));
        return w;
    endfunction

    function automatic line_t ref_line(input logic [31:0] a);
        line_t l;
        for (int i = 0; i < 16; i++)
            l[i*8 +: 8] = ref_byte(a + 32'(i));
        return l;
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        for (int i = 0; i < n; i++)
            rng = lfsr_next(rng);
        v = rng & ((32'h1 << n) - 32'h1);
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    // one cpu request, returns once data_ok is seen
    task automatic access(input logic wr, input tag_t t, input index_t idx,
                          input bank_sel_t w, input strb_t s, input word_t d,
                          input logic hit);
        logic [31:0] a;
        a = {t, idx, w, 2'b00};
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        @(posedge clk);
        cur_op     = wr;
        cur_word   = w;
        expect_hit = hit;
        req_line   = {t, idx, 4'h0};
        exp_rdata  = ref_word(a);
        for (int i = 0; i < STRB_W; i++)
            if (wr && s[i])
                ref_mem[a + 32'(i)] = d[i*8 +: 8];
        valid  <= 1'b1;
        op     <= wr;
        tag    <= t;
        index  <= idx;
        offset <= {w, 2'b00};
        wstrb  <= s;
        wdata  <= d;
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        while (!data_ok)
            @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt != err_mark)
        begin
            tests_failed++;
            $display("test %-16s FAIL, %0d errors", name, err_cnt - err_mark);
        end
        else
            $display("test %-16s ok", name);
        err_mark = err_cnt;
    endtask

    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            reset_q     <= 1'b0;
            after_reset <= 1'b0;
            lookup_q    <= 1'b0;
            wr_req_q    <= 1'b0;
            beat_no     <= '0;
            wb_cnt      <= 0;
            rd_cnt      <= 0;
        end
        else
        begin
            reset_q     <= 1'b1;
            after_reset <= !reset_q;
            lookup_q    <= valid && addr_ok;
            wr_req_q    <= wr_req;
            if (rd_req)
                beat_no <= '0;
            else if (ret_valid)
                beat_no <= beat_no + 3'd1;
            if (wr_req)
                wb_cnt <= wb_cnt + 1;
            if (rd_req)
                rd_cnt <= rd_cnt + 1;
        end
    end

    always @(negedge clk)
        exp_wb_line = ref_line(wr_addr);  // victim line as the cpu last wrote it

    a_reset: assert property (@(posedge clk) disable iff (!resetn)
        after_reset |-> addr_ok && !data_ok && !rd_req && !wr_req)
        else note_failure("outputs after reset are not in their idle values");

    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == req_line)
        else begin
            $display("MISMATCH rd_addr: got 0x%h expected 0x%h",
                     $sampled(rd_addr), $sampled(req_line));
            err_cnt++;
        end

    a_rd_type: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_type == BURST_TYPE)
        else begin
            $display("MISMATCH rd_type: got 0x%h expected 0x%h", $sampled(rd_type), BURST_TYPE);
            err_cnt++;
        end

    a_rdata: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && !cur_op |-> rdata == exp_rdata)
        else begin
            $display("MISMATCH rdata: got 0x%h expected 0x%h",
                     $sampled(rdata), $sampled(exp_rdata));
            err_cnt++;
        end

    a_lookup: assert property (@(posedge clk) disable iff (!resetn)
        lookup_q && (cur_op || expect_hit) |-> data_ok)
        else note_failure("data_ok missing one cycle after acceptance");

    a_refill_beat: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && !cur_op && !lookup_q |-> ret_valid && beat_no == {1'b0, cur_word})
        else note_failure("read miss data_ok not on the beat of the requested word");

    a_hit_no_refill: assert property (@(posedge clk) disable iff (!resetn)
        expect_hit |-> !rd_req)
        else note_failure("refill request issued on an expected hit");

    a_wb_data: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_data == exp_wb_line)
        else begin
            $display("MISMATCH wr_data: got 0x%h expected 0x%h",
                     $sampled(wr_data), $sampled(exp_wb_line));
            err_cnt++;
        end

    a_wb_strb: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_wstrb == 4'hf)
        else begin
            $display("MISMATCH wr_wstrb: got 0x%h expected 0xf", $sampled(wr_wstrb));
            err_cnt++;
        end

    a_wb_type: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_type == BURST_TYPE)
        else begin
            $display("MISMATCH wr_type: got 0x%h expected 0x%h", $sampled(wr_type), BURST_TYPE);
            err_cnt++;
        end

    a_wb_addr: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && check_wb_addr |-> wr_addr == exp_wb_addr)
        else begin
            $display("MISMATCH wr_addr: got 0x%h expected 0x%h",
                     $sampled(wr_addr), $sampled(exp_wb_addr));
            err_cnt++;
        end

    a_wb_single: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> !wr_req_q)
        else note_failure("wr_req held for more than one cycle");

    a_clean_victim: assert property (@(posedge clk) disable iff (!resetn)
        expect_clean |-> !wr_req)
        else note_failure("write-back issued for a clean victim");

    initial
    begin
        #((RESET_CYCLES + 10 + N_REQ * MISS_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        logic [31:0] r_op;
        logic [31:0] r_set;
        logic [31:0] r_tag;
        logic [31:0] r_word;
        logic [31:0] r_strb;
        logic [31:0] r_data;
        int          mark;

        resetn        = 1'b0;
        valid         = 1'b0;
        op            = 1'b0;
        index         = '0;
        tag           = '0;
        offset        = '0;
        wstrb         = '0;
        wdata         = '0;
        cur_op        = 1'b0;
        cur_word      = '0;
        expect_hit    = 1'b0;
        expect_clean  = 1'b0;
        check_wb_addr = 1'b0;
        exp_wb_addr   = '0;
        req_line      = '0;
        exp_rdata     = '0;
        err_cnt       = 0;
        err_mark      = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);
        finish_test("reset");

        mark = rd_cnt;
        access(1'b0, 20'h00011, 8'h05, 2'd2, 4'h0, '0, 1'b0);  // cold miss
        if (rd_cnt == mark)
            note_failure("cold read miss issued no refill request");
        access(1'b0, 20'h00011, 8'h05, 2'd0, 4'h0, '0, 1'b1);
        finish_test("read miss");

        access(1'b1, 20'h00011, 8'h05, 2'd1, 4'b0101, 32'hdead_beef, 1'b1);
        access(1'b0, 20'h00011, 8'h05, 2'd1, 4'h0, '0, 1'b1);
        finish_test("write hit");

        access(1'b1, 20'h00022, 8'h09, 2'd3, 4'b1100, 32'h1234_5678, 1'b0);
        access(1'b0, 20'h00022, 8'h09, 2'd3, 4'h0, '0, 1'b1);
        finish_test("write miss");

        access(1'b0, 20'h00033, 8'h05, 2'd0, 4'h0, '0, 1'b0);  // fills way 1
        exp_wb_addr   = {20'h00011, 8'h05, 4'h0};
        check_wb_addr = 1'b1;
        mark          = wb_cnt;
        access(1'b0, 20'h00044, 8'h05, 2'd3, 4'h0, '0, 1'b0);  // dirty way 0 out
        if (wb_cnt != mark + 1)
            note_failure("dirty victim was not written back exactly once");
        check_wb_addr = 1'b0;
        expect_clean  = 1'b1;
        access(1'b0, 20'h00066, 8'h05, 2'd1, 4'h0, '0, 1'b0);  // clean way 0 out
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        expect_clean = 1'b0;
        finish_test("eviction");

        for (int n = 0; n < N_RANDOM; n++)
        begin
            draw(1, r_op);
            draw(2, r_set);
            draw(3, r_tag);
            draw(2, r_word);
            draw(4, r_strb);
            draw(32, r_data);
            access(r_op[0], tag_t'(TAG_BASE + r_tag % 6), index_t'(IDX_BASE + r_set),
                   bank_sel_t'(r_word), strb_t'(r_strb), r_data, 1'b0);
        end
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        finish_test("random mix");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
